/* biu_pkg.sv */
/*
 * Shared types for the BIU to Wishbone subsystem.
 * Burst and size encodings of the core request port, the Wishbone
 * cycle-type and burst-extension tags, and the bridge FSM states.
 * Modules refer to these by scoped names.
 */

package biu_pkg;

  ////////////////////
  // core request side
  ////////////////////

  // burst type as issued by the core
  typedef enum logic [2:0] {
    SINGLE = 3'd0,
    INCR   = 3'd1,  // undefined length, run as one beat
    WRAP4  = 3'd2,
    INCR4  = 3'd3,
    WRAP8  = 3'd4,
    INCR8  = 3'd5,
    WRAP16 = 3'd6,
    INCR16 = 3'd7
  } biu_type_e;

  typedef enum logic [2:0] {
    SIZE_BYTE  = 3'd0,
    SIZE_HWORD = 3'd1,
    SIZE_WORD  = 3'd2,
    SIZE_DWORD = 3'd3
  } biu_size_e;

  localparam int BURST_CNT_W = 4;  // beats-1, up to 15

  ////////////////////
  // wishbone tags
  ////////////////////

  typedef enum logic [2:0] {
    CTI_CLASSIC = 3'b000,
    CTI_INCR    = 3'b010,  // incrementing burst, more beats follow
    CTI_EOB     = 3'b111   // last beat of the burst
  } wb_cti_e;

  typedef enum logic [1:0] {
    BTE_LINEAR = 2'b00,
    BTE_WRAP4  = 2'b01,
    BTE_WRAP8  = 2'b10,
    BTE_WRAP16 = 2'b11
  } wb_bte_e;

  // bridge fsm
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_BEAT = 2'd1,
    ST_ERR  = 2'd2
  } bridge_state_e;

endpackage

/* biu2wb_bridge.sv */
/*
 * Core BIU request port to Wishbone B4 master.
 * Accepts one request per strobe, runs it as a single or an
 * incrementing/wrapping burst, returns read data and the beat address
 * one cycle after each Wishbone acknowledge, and aborts on bus error.
 */

`timescale 1ns/100ps

module biu2wb_bridge #(
  parameter int XLEN = 32,
  parameter int PLEN = 32
) (
  input  logic                     HCLK,
  input  logic                     HRESETn,

  // core side
  input  logic                     biu_stb_i,
  output logic                     biu_stb_ack_o,
  output logic                     biu_d_ack_o,
  input  logic [PLEN-1:0]          biu_adri_i,
  output logic [PLEN-1:0]          biu_adro_o,
  input  biu_pkg::biu_size_e       biu_size_i,
  input  biu_pkg::biu_type_e       biu_type_i,
  input  logic                     biu_we_i,
  input  logic [XLEN-1:0]          biu_d_i,
  output logic [XLEN-1:0]          biu_q_o,
  output logic                     biu_ack_o,
  output logic                     biu_err_o,

  // wishbone master
  output logic [PLEN-1:0]          wb_adr_o,
  output logic [XLEN-1:0]          wb_dat_o,
  output logic [XLEN/8-1:0]        wb_sel_o,
  output logic                     wb_we_o,
  output logic                     wb_cyc_o,
  output logic                     wb_stb_o,
  output biu_pkg::wb_cti_e         wb_cti_o,
  output biu_pkg::wb_bte_e         wb_bte_o,
  input  logic [XLEN-1:0]          wb_dat_i,
  input  logic                     wb_ack_i,
  input  logic                     wb_err_i
);

  localparam int SEL_W = XLEN / 8;
  localparam int OFS   = $clog2(SEL_W);  // byte offset bits within a word

  ////////////////////
  // conversions
  ////////////////////

  // burst type -> beats minus one
  function automatic logic [biu_pkg::BURST_CNT_W-1:0] type2cnt(input biu_pkg::biu_type_e t);
    case (t)
      biu_pkg::WRAP4, biu_pkg::INCR4:   return 4'd3;
      biu_pkg::WRAP8, biu_pkg::INCR8:   return 4'd7;
      biu_pkg::WRAP16, biu_pkg::INCR16: return 4'd15;
      default:                          return 4'd0;  // SINGLE, INCR
    endcase
  endfunction

  function automatic biu_pkg::wb_bte_e type2bte(input biu_pkg::biu_type_e t);
    case (t)
      biu_pkg::WRAP4:  return biu_pkg::BTE_WRAP4;
      biu_pkg::WRAP8:  return biu_pkg::BTE_WRAP8;
      biu_pkg::WRAP16: return biu_pkg::BTE_WRAP16;
      default:         return biu_pkg::BTE_LINEAR;
    endcase
  endfunction

  // byte lanes from size and low address bits, aligned to the size
  function automatic logic [SEL_W-1:0] size2sel(input biu_pkg::biu_size_e sz,
                                                input logic [PLEN-1:0] adr);
    logic [SEL_W-1:0] lanes;
    logic [OFS-1:0]   ofs;
    ofs = adr[OFS-1:0];
    case (sz)
      biu_pkg::SIZE_BYTE: lanes = SEL_W'(1);
      biu_pkg::SIZE_HWORD: begin
        lanes = SEL_W'(3);
        ofs   = ofs & ~OFS'(1);
      end
      biu_pkg::SIZE_WORD: begin
        lanes = SEL_W'(4'hf);
        ofs   = ofs & ~OFS'(3);  // zero for 32 bit data
      end
      default: begin
        lanes = '1;  // dword, whole bus
        ofs   = '0;
      end
    endcase
    return lanes << ofs;
  endfunction

  // next beat address, wraps inside beats*SEL_W bytes
  function automatic logic [PLEN-1:0] nxt_addr(input logic [PLEN-1:0] adr,
                                               input biu_pkg::wb_bte_e bte);
    logic [PLEN-1:0] lin;
    logic [PLEN-1:0] wmask;
    lin = (adr + PLEN'(SEL_W)) & ~PLEN'(SEL_W - 1);
    case (bte)
      biu_pkg::BTE_WRAP4:  wmask = PLEN'(4 * SEL_W - 1);
      biu_pkg::BTE_WRAP8:  wmask = PLEN'(8 * SEL_W - 1);
      biu_pkg::BTE_WRAP16: wmask = PLEN'(16 * SEL_W - 1);
      default:             wmask = '1;  // linear
    endcase
    return (adr & ~wmask) | (lin & wmask);
  endfunction

  ////////////////////
  // control
  ////////////////////

  biu_pkg::bridge_state_e              state;
  logic [biu_pkg::BURST_CNT_W-1:0]     burst_cnt;  // beats left after current
  logic                                beat_ack;
  logic                                more;

  assign beat_ack = (state == biu_pkg::ST_BEAT) & wb_ack_i & ~wb_err_i;
  assign more     = |burst_cnt;

  assign biu_stb_ack_o = biu_stb_i & (state == biu_pkg::ST_IDLE);  // accept in idle only
  // beat 0 data at accept, beat n+1 data on beat n ack
  assign biu_d_ack_o   = (biu_stb_ack_o & biu_we_i) | (beat_ack & more & wb_we_o);
  assign biu_err_o     = (state == biu_pkg::ST_ERR);  // one cycle after wb error

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state     <= biu_pkg::ST_IDLE;
      burst_cnt <= '0;
      wb_cyc_o  <= 1'b0;
      wb_stb_o  <= 1'b0;
      wb_we_o   <= 1'b0;
      wb_cti_o  <= biu_pkg::CTI_CLASSIC;
      wb_bte_o  <= biu_pkg::BTE_LINEAR;
      biu_ack_o <= 1'b0;
    end else begin
      biu_ack_o <= 1'b0;
      case (state)
        biu_pkg::ST_IDLE: begin
          if (biu_stb_i) begin
            state     <= biu_pkg::ST_BEAT;
            burst_cnt <= type2cnt(biu_type_i);
            wb_cyc_o  <= 1'b1;
            wb_stb_o  <= 1'b1;
            wb_we_o   <= biu_we_i;
            wb_bte_o  <= type2bte(biu_type_i);
            wb_cti_o  <= (type2cnt(biu_type_i) == '0) ? biu_pkg::CTI_CLASSIC
                                                      : biu_pkg::CTI_INCR;
          end
        end
        biu_pkg::ST_BEAT: begin
          if (wb_err_i) begin  // abandon rest of burst
            state     <= biu_pkg::ST_ERR;
            burst_cnt <= '0;
            wb_cyc_o  <= 1'b0;
            wb_stb_o  <= 1'b0;
          end else if (wb_ack_i) begin
            biu_ack_o <= 1'b1;
            if (!more) begin
              state    <= biu_pkg::ST_IDLE;
              wb_cyc_o <= 1'b0;
              wb_stb_o <= 1'b0;
            end else begin
              burst_cnt <= burst_cnt - 1'b1;
              wb_cti_o  <= (burst_cnt == 4'd1) ? biu_pkg::CTI_EOB : biu_pkg::CTI_INCR;
            end
          end
        end
        default: state <= biu_pkg::ST_IDLE;  // ST_ERR, single cycle
      endcase
    end
  end

  ////////////////////
  // payload
  ////////////////////

  always_ff @(posedge HCLK) begin
    if (biu_stb_ack_o) begin
      wb_adr_o <= biu_adri_i;
      wb_dat_o <= biu_d_i;
      wb_sel_o <= size2sel(biu_size_i, biu_adri_i);
    end else if (beat_ack && more) begin
      wb_adr_o <= nxt_addr(wb_adr_o, wb_bte_o);
      wb_dat_o <= biu_d_i;  // next beat, presented after d_ack
    end

    if (beat_ack) begin
      biu_q_o    <= wb_dat_i;
      biu_adro_o <= wb_adr_o;  // address of the beat just acked
    end
  end

endmodule

/* wb_sram_slave.sv */
/*
 * Wishbone slave SRAM.
 * Word-wide array with byte-lane writes. Each beat is acknowledged
 * 1+WAIT_STATES cycles after the strobe is seen, with the acknowledge
 * low for a cycle between beats. Addresses past the array get an error.
 */

`timescale 1ns/100ps

module wb_sram_slave #(
  parameter int XLEN        = 32,
  parameter int PLEN        = 32,
  parameter int MEM_WORDS   = 256,
  parameter int WAIT_STATES = 1
) (
  input  logic                HCLK,
  input  logic                HRESETn,

  input  logic [PLEN-1:0]     wb_adr_i,
  input  logic [XLEN-1:0]     wb_dat_i,
  input  logic [XLEN/8-1:0]   wb_sel_i,
  input  logic                wb_we_i,
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  biu_pkg::wb_cti_e    wb_cti_i,
  input  biu_pkg::wb_bte_e    wb_bte_i,
  output logic [XLEN-1:0]     wb_dat_o,
  output logic                wb_ack_o,
  output logic                wb_err_o
);

  localparam int SEL_W = XLEN / 8;
  localparam int OFS   = $clog2(SEL_W);
  localparam int AW    = $clog2(MEM_WORDS);
  localparam logic [PLEN-1:0] MEM_BYTES = PLEN'(MEM_WORDS * SEL_W);

  logic [XLEN-1:0] mem [MEM_WORDS];

  logic [1:0]      wait_cnt;   // cycles spent on the pending beat
  logic            closed_q;   // burst ended, ignore strobe until it drops
  logic            req;
  logic            beat_go;
  logic            fire;
  logic            in_range;
  logic            last_beat;
  logic [AW-1:0]   idx;

  ////////////////////
  // decode
  ////////////////////

  assign req       = wb_cyc_i & wb_stb_i;
  assign beat_go   = req & ~closed_q & ~wb_ack_o & ~wb_err_o;  // ack cycle is the gap
  assign fire      = beat_go & (wait_cnt == 2'(WAIT_STATES));
  assign in_range  = wb_adr_i < MEM_BYTES;
  assign last_beat = (wb_cti_i == biu_pkg::CTI_EOB) | (wb_cti_i == biu_pkg::CTI_CLASSIC);
  assign idx       = wb_adr_i[OFS +: AW];  // word index

  ////////////////////
  // handshake
  ////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wait_cnt <= '0;
      closed_q <= 1'b0;
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else begin
      wb_ack_o <= 1'b0;  // single-cycle responses
      wb_err_o <= 1'b0;

      if (!req) closed_q <= 1'b0;
      else if (fire && last_beat) closed_q <= 1'b1;  // EOB or classic closes the cycle

      if (!req || closed_q) begin
        wait_cnt <= '0;
      end else if (fire) begin
        wait_cnt <= '0;  // next beat counts from zero
        if (in_range) wb_ack_o <= 1'b1;
        else          wb_err_o <= 1'b1;
      end else if (beat_go) begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end
  end

  ////////////////////
  // array
  ////////////////////

  always_ff @(posedge HCLK) begin
    if (fire && in_range) begin
      if (wb_we_i) begin
        for (int i = 0; i < SEL_W; i++) begin
          if (wb_sel_i[i]) mem[idx][8*i +: 8] <= wb_dat_i[8*i +: 8];
        end
      end
      wb_dat_o <= mem[idx];  // valid with the ack
    end
  end

endmodule

/* biu_wb_subsystem.sv */
/*
 * Subsystem top level.
 * The core BIU port drives the Wishbone bridge, which masters the
 * on-chip SRAM slave. Parameters are set here and passed down.
 */

`timescale 1ns/100ps

module biu_wb_subsystem #(
  parameter int XLEN        = 32,
  parameter int PLEN        = 32,
  parameter int MEM_WORDS   = 256,
  parameter int WAIT_STATES = 1
) (
  input  logic                 HCLK,
  input  logic                 HRESETn,

  input  logic                 biu_stb_i,
  output logic                 biu_stb_ack_o,
  output logic                 biu_d_ack_o,
  input  logic [PLEN-1:0]      biu_adri_i,
  output logic [PLEN-1:0]      biu_adro_o,
  input  biu_pkg::biu_size_e   biu_size_i,
  input  biu_pkg::biu_type_e   biu_type_i,
  input  logic                 biu_we_i,
  input  logic [XLEN-1:0]      biu_d_i,
  output logic [XLEN-1:0]      biu_q_o,
  output logic                 biu_ack_o,
  output logic                 biu_err_o
);

  ////////////////////
  // wishbone wires
  ////////////////////

  logic [PLEN-1:0]    wb_adr;
  logic [XLEN-1:0]    wb_wdat;    // master to slave
  logic [XLEN-1:0]    wb_rdat;    // slave to master
  logic [XLEN/8-1:0]  wb_sel;
  logic               wb_we;
  logic               wb_cyc;
  logic               wb_stb;
  biu_pkg::wb_cti_e   wb_cti;
  biu_pkg::wb_bte_e   wb_bte;
  logic               wb_ack;
  logic               wb_err;

  biu2wb_bridge #(
    .XLEN (XLEN),
    .PLEN (PLEN)
  ) u_bridge (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .biu_stb_i     (biu_stb_i),
    .biu_stb_ack_o (biu_stb_ack_o),
    .biu_d_ack_o   (biu_d_ack_o),
    .biu_adri_i    (biu_adri_i),
    .biu_adro_o    (biu_adro_o),
    .biu_size_i    (biu_size_i),
    .biu_type_i    (biu_type_i),
    .biu_we_i      (biu_we_i),
    .biu_d_i       (biu_d_i),
    .biu_q_o       (biu_q_o),
    .biu_ack_o     (biu_ack_o),
    .biu_err_o     (biu_err_o),
    .wb_adr_o      (wb_adr),
    .wb_dat_o      (wb_wdat),
    .wb_sel_o      (wb_sel),
    .wb_we_o       (wb_we),
    .wb_cyc_o      (wb_cyc),
    .wb_stb_o      (wb_stb),
    .wb_cti_o      (wb_cti),
    .wb_bte_o      (wb_bte),
    .wb_dat_i      (wb_rdat),
    .wb_ack_i      (wb_ack),
    .wb_err_i      (wb_err)
  );

  wb_sram_slave #(
    .XLEN        (XLEN),
    .PLEN        (PLEN),
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) u_sram (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_wdat),
    .wb_sel_i (wb_sel),
    .wb_we_i  (wb_we),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_cti_i (wb_cti),
    .wb_bte_i (wb_bte),
    .wb_dat_o (wb_rdat),
    .wb_ack_o (wb_ack),
    .wb_err_o (wb_err)
  );

endmodule

/* biu_wb_sva.sv */
/*
 * Wishbone and BIU handshake assertions.
 * Bound into every bridge instance by the bind at the bottom.
 */

`timescale 1ns/100ps

module biu_wb_sva #(
  parameter int XLEN = 32,
  parameter int PLEN = 32
) (
  input logic                   HCLK,
  input logic                   HRESETn,
  input logic                   cyc_i,
  input logic                   stb_i,
  input logic [PLEN-1:0]        adr_i,
  input logic [XLEN/8-1:0]      sel_i,
  input logic [XLEN-1:0]        dat_i,
  input biu_pkg::wb_cti_e       cti_i,
  input logic                   ack_i,
  input logic                   err_i,
  input logic                   biu_ack_i,
  input logic                   biu_err_i,
  input biu_pkg::bridge_state_e state_i
);

  a_stb_cyc: assert property (@(posedge HCLK) disable iff (!HRESETn) stb_i |-> cyc_i)
    else $error("wishbone stb high without cyc");

  // request payload held until the slave answers
  a_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
    stb_i && !ack_i && !err_i |=> $stable(adr_i) && $stable(sel_i) && $stable(dat_i)
                                  && $stable(cti_i))
    else $error("wishbone request changed while waiting for ack");

  a_ack_err: assert property (@(posedge HCLK) disable iff (!HRESETn) !(biu_ack_i && biu_err_i))
    else $error("biu ack and err high together");

  a_abort: assert property (@(posedge HCLK) disable iff (!HRESETn)
    cyc_i && err_i |=> !cyc_i && state_i == biu_pkg::ST_ERR)
    else $error("bus error did not end the cycle");

  a_rst: assert property (@(posedge HCLK) $rose(HRESETn) |-> !cyc_i)
    else $error("cyc high coming out of reset");

endmodule

bind biu2wb_bridge biu_wb_sva #(
  .XLEN (XLEN),
  .PLEN (PLEN)
) u_sva (
  .HCLK      (HCLK),
  .HRESETn   (HRESETn),
  .cyc_i     (wb_cyc_o),
  .stb_i     (wb_stb_o),
  .adr_i     (wb_adr_o),
  .sel_i     (wb_sel_o),
  .dat_i     (wb_dat_o),
  .cti_i     (wb_cti_o),
  .ack_i     (wb_ack_i),
  .err_i     (wb_err_i),
  .biu_ack_i (biu_ack_o),
  .biu_err_i (biu_err_o),
  .state_i   (state)
);

/* tb_biu_wb.sv */
/*
 * Directed testbench for the BIU to Wishbone subsystem.
 * Acts as the core on the BIU port and keeps a reference copy of the SRAM.
 * Covers singles, incrementing and wrapping bursts, error abort and
 * random singles, and stops at the first mismatch.
 */

`timescale 1ns/100ps

module tb_biu_wb;

  localparam int XLEN        = 32;
  localparam int PLEN        = 32;
  localparam int MEM_WORDS   = 256;
  localparam int WAIT_STATES = 1;
  localparam int SEL_W       = XLEN / 8;
  localparam int TIMEOUT     = 100;  // cycles per wait loop
  localparam logic [PLEN-1:0] MEM_BYTES = PLEN'(MEM_WORDS * SEL_W);

  logic                HCLK = 1'b0;
  logic                HRESETn;
  logic                biu_stb_i;
  logic                biu_stb_ack_o;
  logic                biu_d_ack_o;
  logic [PLEN-1:0]     biu_adri_i;
  logic [PLEN-1:0]     biu_adro_o;
  biu_pkg::biu_size_e  biu_size_i;
  biu_pkg::biu_type_e  biu_type_i;
  logic                biu_we_i;
  logic [XLEN-1:0]     biu_d_i;
  logic [XLEN-1:0]     biu_q_o;
  logic                biu_ack_o;
  logic                biu_err_o;

  logic [XLEN-1:0]     ref_mem [MEM_WORDS];  // expected sram contents
  logic [XLEN-1:0]     wbuf [16];            // write data per beat
  logic [XLEN-1:0]     rq [16];              // captured biu_q_o
  logic [PLEN-1:0]     ra [16];              // captured biu_adro_o
  int                  n_ack;
  int                  n_err;
  int                  n_dack;               // write data acknowledges seen
  integer              seed = 94759;
  bit                  fail_shown = 1'b0;
  bit                  pass_shown = 1'b0;

  always #5 HCLK = ~HCLK;

  biu_wb_subsystem #(
    .XLEN        (XLEN),
    .PLEN        (PLEN),
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) dut0 (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .biu_stb_i     (biu_stb_i),
    .biu_stb_ack_o (biu_stb_ack_o),
    .biu_d_ack_o   (biu_d_ack_o),
    .biu_adri_i    (biu_adri_i),
    .biu_adro_o    (biu_adro_o),
    .biu_size_i    (biu_size_i),
    .biu_type_i    (biu_type_i),
    .biu_we_i      (biu_we_i),
    .biu_d_i       (biu_d_i),
    .biu_q_o       (biu_q_o),
    .biu_ack_o     (biu_ack_o),
    .biu_err_o     (biu_err_o)
  );

  ////////////////////
  // reference model
  ////////////////////

  function automatic int beats_of(input biu_pkg::biu_type_e bt);
    case (bt)
      biu_pkg::WRAP4, biu_pkg::INCR4:   return 4;
      biu_pkg::WRAP8, biu_pkg::INCR8:   return 8;
      biu_pkg::WRAP16, biu_pkg::INCR16: return 16;
      default:                          return 1;  // single, open incr
    endcase
  endfunction

  // lanes of 2**size bytes, aligned to the size inside the word
  function automatic logic [SEL_W-1:0] lanes_of(input biu_pkg::biu_size_e sz,
                                                input logic [PLEN-1:0] a);
    int n;
    int ofs;
    n = 1 << int'(sz);
    if (n > SEL_W) n = SEL_W;
    ofs = int'(a % SEL_W) & ~(n - 1);
    return SEL_W'((1 << n) - 1) << ofs;
  endfunction

  // address of beat i, wrapping inside the aligned block for wrap types
  function automatic logic [PLEN-1:0] beat_addr(input biu_pkg::biu_type_e bt,
                                                input logic [PLEN-1:0] start,
                                                input int i);
    logic [PLEN-1:0] lin;
    logic [PLEN-1:0] blk;
    lin = start + PLEN'(i * SEL_W);
    blk = PLEN'(beats_of(bt) * SEL_W);
    if (bt inside {biu_pkg::WRAP4, biu_pkg::WRAP8, biu_pkg::WRAP16})
      return (start & ~(blk - 1)) | (lin & (blk - 1));
    return lin;
  endfunction

  function automatic logic [XLEN-1:0] fill_word(input logic [PLEN-1:0] a);
    return XLEN'(a) ^ (XLEN'(a) << 13) ^ XLEN'(32'h5a3c_96e1);
  endfunction

  function automatic void merge_ref(input logic [PLEN-1:0] a, input logic [SEL_W-1:0] ln,
                                    input logic [XLEN-1:0] d);
    for (int l = 0; l < SEL_W; l++) begin
      if (ln[l]) ref_mem[int'(a / SEL_W)][8*l +: 8] = d[8*l +: 8];
    end
  endfunction

  ////////////////////
  // checks
  ////////////////////

  task automatic fail_now(input string why);
    fail_shown = 1'b1;
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    if (got !== exp) fail_now($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input logic [PLEN-1:0] got,
                            input logic [PLEN-1:0] exp);
    if (got !== exp) fail_now($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) fail_now($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) fail_now($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  ////////////////////
  // core side driver
  ////////////////////

  // one request, collects every ack or the error, then a quiet window
  task automatic biu_xfer(input logic we, input biu_pkg::biu_type_e bt,
                          input biu_pkg::biu_size_e sz, input logic [PLEN-1:0] adr);
    int  nb;
    int  dk;
    int  tmo;
    logic pend;
    nb     = beats_of(bt);
    n_ack  = 0;
    n_err  = 0;
    n_dack = 0;
    dk     = 0;
    tmo    = 0;
    @(negedge HCLK);
    biu_stb_i  = 1'b1;
    biu_we_i   = we;
    biu_type_i = bt;
    biu_size_i = sz;
    biu_adri_i = adr;
    biu_d_i    = wbuf[0];
    #1;
    while (!biu_stb_ack_o) begin  // held until accepted
      tmo++;
      if (tmo > TIMEOUT) fail_now("request was never accepted by the bridge");
      @(negedge HCLK);
      #1;
    end
    pend = biu_d_ack_o;  // beat 0 taken at accept
    if (pend) n_dack++;
    tmo  = 0;
    while (n_ack < nb && n_err == 0) begin
      @(negedge HCLK);
      biu_stb_i = 1'b0;
      if (pend && dk < nb - 1) begin  // previous data consumed, show next beat
        dk++;
        biu_d_i = wbuf[dk];
      end
      pend = biu_d_ack_o;
      if (pend) n_dack++;
      if (biu_ack_o) begin
        ra[n_ack] = biu_adro_o;
        rq[n_ack] = biu_q_o;
        n_ack++;
      end
      if (biu_err_o) n_err++;
      tmo++;
      if (tmo > TIMEOUT) fail_now("transfer did not finish, acknowledges stopped");
    end
    repeat (3) begin
      @(negedge HCLK);
      if (biu_ack_o || biu_err_o || biu_d_ack_o || biu_stb_ack_o)
        fail_now("response seen after the transfer had ended");
    end
  endtask

  task automatic do_write(input biu_pkg::biu_type_e bt, input biu_pkg::biu_size_e sz,
                          input logic [PLEN-1:0] adr);
    logic [PLEN-1:0] a;
    biu_xfer(1'b1, bt, sz, adr);
    check_flag("biu_err_o", n_err != 0, 1'b0);
    check_count("biu_ack_o pulses", n_ack, beats_of(bt));
    check_count("biu_d_ack_o pulses", n_dack, beats_of(bt));
    for (int i = 0; i < n_ack; i++) begin
      a = beat_addr(bt, adr, i);
      check_addr("biu_adro_o", ra[i], a);
      merge_ref(a, lanes_of(sz, a), wbuf[i]);
    end
  endtask

  task automatic do_read(input biu_pkg::biu_type_e bt, input logic [PLEN-1:0] adr);
    logic [PLEN-1:0] a;
    biu_xfer(1'b0, bt, biu_pkg::SIZE_WORD, adr);
    check_flag("biu_err_o", n_err != 0, 1'b0);
    check_count("biu_ack_o pulses", n_ack, beats_of(bt));
    check_count("biu_d_ack_o pulses", n_dack, 0);  // reads take no write data
    for (int i = 0; i < n_ack; i++) begin
      a = beat_addr(bt, adr, i);
      check_addr("biu_adro_o", ra[i], a);
      check_data("biu_q_o", rq[i], ref_mem[int'(a / SEL_W)]);
    end
  endtask

  // write then read back a burst of random words
  task automatic burst_pair(input biu_pkg::biu_type_e bt, input logic [PLEN-1:0] adr);
    for (int i = 0; i < 16; i++) wbuf[i] = $random(seed);
    do_write(bt, biu_pkg::SIZE_WORD, adr);
    do_read(bt, adr);
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic test_singles();
    for (int o = 0; o < 4; o++) begin
      wbuf[0] = $random(seed);
      do_write(biu_pkg::SINGLE, biu_pkg::SIZE_BYTE, PLEN'('h40 + o));
      wbuf[0] = $random(seed);
      do_write(biu_pkg::SINGLE, biu_pkg::SIZE_HWORD, PLEN'('h44 + 2 * o));
    end
    wbuf[0] = $random(seed);
    do_write(biu_pkg::SINGLE, biu_pkg::SIZE_WORD, 'h4c);
    wbuf[0] = $random(seed);
    do_write(biu_pkg::INCR, biu_pkg::SIZE_WORD, 'h50);  // open length, one beat
    for (int w = 0; w < 5; w++) do_read(biu_pkg::SINGLE, PLEN'('h40 + 4 * w));
  endtask

  task automatic test_error();
    biu_xfer(1'b0, biu_pkg::INCR4, biu_pkg::SIZE_WORD, MEM_BYTES + 'h10);
    check_count("biu_err_o pulses", n_err, 1);
    check_count("biu_ack_o pulses", n_ack, 0);
    check_count("biu_d_ack_o pulses", n_dack, 0);
    wbuf[0] = $random(seed);
    biu_xfer(1'b1, biu_pkg::INCR8, biu_pkg::SIZE_WORD, MEM_BYTES + 'h40);
    check_count("biu_err_o pulses", n_err, 1);
    check_count("biu_ack_o pulses", n_ack, 0);
    check_count("biu_d_ack_o pulses", n_dack, 1);  // only beat 0 at accept
    wbuf[0] = $random(seed);
    do_write(biu_pkg::SINGLE, biu_pkg::SIZE_WORD, 'h60);  // bus usable again
    do_read(biu_pkg::SINGLE, 'h60);
  endtask

  task automatic test_random();
    logic [PLEN-1:0]    adr;
    biu_pkg::biu_size_e sz;
    for (int n = 0; n < 40; n++) begin
      sz  = biu_pkg::biu_size_e'(3'($unsigned($random(seed)) % 3));
      adr = PLEN'($random(seed)) & (MEM_BYTES - 1);
      adr = adr & ~((PLEN'(1) << sz) - 1);  // size aligned
      wbuf[0] = $random(seed);
      do_write(biu_pkg::SINGLE, sz, adr);
      do_read(biu_pkg::SINGLE, adr & ~PLEN'(SEL_W - 1));
    end
  endtask

  initial begin
    HRESETn    = 1'b0;
    biu_stb_i  = 1'b0;
    biu_we_i   = 1'b0;
    biu_adri_i = '0;
    biu_d_i    = '0;
    biu_size_i = biu_pkg::SIZE_WORD;
    biu_type_i = biu_pkg::SINGLE;
    repeat (2) @(posedge HCLK);
    @(negedge HCLK) HRESETn = 1'b1;
    check_flag("biu_ack_o", biu_ack_o, 1'b0);  // quiet out of reset
    check_flag("biu_err_o", biu_err_o, 1'b0);
    check_flag("biu_d_ack_o", biu_d_ack_o, 1'b0);
    check_flag("biu_stb_ack_o", biu_stb_ack_o, 1'b0);

    // known contents everywhere, so byte reads never see X
    for (int b = 0; b < MEM_WORDS / 16; b++) begin
      for (int i = 0; i < 16; i++) wbuf[i] = fill_word(PLEN'((b * 16 + i) * SEL_W));
      do_write(biu_pkg::INCR16, biu_pkg::SIZE_WORD, PLEN'(b * 16 * SEL_W));
    end
    test_singles();
    burst_pair(biu_pkg::INCR4, 'h100);
    burst_pair(biu_pkg::INCR8, 'h180);
    burst_pair(biu_pkg::INCR16, 'h200);
    burst_pair(biu_pkg::WRAP4, 'h308);   // mid-line starts
    burst_pair(biu_pkg::WRAP8, 'h334);
    burst_pair(biu_pkg::WRAP16, 'h3a8);
    test_error();
    test_random();

    pass_shown = 1'b1;
    $display("*** TEST PASSED ***");
    $finish;
  end

  // run stopped by an assertion or otherwise without a verdict
  final begin
    if (!pass_shown && !fail_shown) $display("*** TEST FAILED ***");
  end

endmodule

/* sources.f */
biu_pkg.sv
biu2wb_bridge.sv
wb_sram_slave.sv
biu_wb_subsystem.sv
biu_wb_sva.sv
tb_biu_wb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_biu_wb -f sources.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_biu_wb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF '*** TEST PASSED ***' "$LOG"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed, no pass line in $LOG"
exit 1
